// ==== Makefile ====
# Verilator build and run of the peripheral bus testbench

VERILATOR ?= verilator
TOP ?= periph_bus_tb
FILELIST ?= vlog.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
EXTRA_FLAGS ?=

# sources from the file list, include dirs dropped
SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard src/*.svh)
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source, header or the file list changes
$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) $(EXTRA_FLAGS) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST) -o V$(TOP)

# exit status of the binary is the test result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/periph_bus_assert.sv ====
`timescale 1ns/1ps

// handshake properties of the responder
module periph_bus_assert (
	input logic clk_24,
	input logic rst_n,
	input logic req_ready,
	input periph_pkg::byte_t rsp_data,
	input logic rsp_valid,
	input logic rsp_ready
);
	// no response straight out of reset
	a_rsp_idle_after_reset: assert property (@(posedge clk_24) !rst_n |=> !rsp_valid)
		else $error("rsp_valid high in the cycle after reset");

	// held response keeps its byte and its valid
	a_rsp_held: assert property (@(posedge clk_24) disable iff (!rst_n)
		(rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp_data)))
		else $error("response changed while the master held it off");

	// request side closed under back-pressure
	a_req_blocked: assert property (@(posedge clk_24) disable iff (!rst_n)
		(rsp_valid && !rsp_ready) |-> !req_ready)
		else $error("req_ready high while the response was stalled");

endmodule

// attach to every responder instance
bind bus_responder periph_bus_assert u_resp_assert (
	.clk_24(clk_24),
	.rst_n(rst_n),
	.req_ready(req_ready),
	.rsp_data(rsp_data),
	.rsp_valid(rsp_valid),
	.rsp_ready(rsp_ready)
);

// ==== sim/periph_bus_tb.sv ====
`timescale 1ns/1ps
`include "periph_macros.svh"

module periph_bus_tb;
	// timer divider for simulation, 50 clocks per tick
	localparam int TB_DIV = 50;
	localparam int TIMER_MS = 4;
	localparam int N_SWEEP = 256;
	localparam int N_WRITES = 16;
	localparam int N_UNMAPPED = 16;
	localparam int N_BP = 150;
	localparam int N_TXN = N_SWEEP + 2 * N_WRITES + N_UNMAPPED + N_BP + 4;
	localparam int WATCHDOG_CYCLES = N_TXN * 20 + TIMER_MS * TB_DIV + 100;
	// how the compare process treats a response
	localparam int KIND_REF = 0;
	localparam int KIND_FIXED = 1;
	localparam int KIND_TIMER_LO = 2;
	localparam int KIND_TIMER_HI = 3;

	logic clk_24;
	logic rst_n;
	periph_pkg::bus_req_t req;
	logic req_valid;
	logic req_ready;
	periph_pkg::byte_t rsp_data;
	logic rsp_valid;
	logic rsp_ready;
	periph_pkg::player_inputs_t inputs;

	int seed = 32'h1999;
	int bp_seed = 32'h1999;
	logic bp_on = 1'b0;
	int err_count = 0;
	int sent_count = 0;
	int rsp_count = 0;
	periph_pkg::byte_t timer_lo;
	periph_pkg::byte_t timer_hi;
	// outstanding responses, oldest first
	periph_pkg::byte_t exp_q[$];
	int kind_q[$];
	string name_q[$];

	periph_bus_top #(
		.timer_div(32'(TB_DIV))
	) uut (
		.clk_24(clk_24),
		.rst_n(rst_n),
		.req(req),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.rsp_data(rsp_data),
		.rsp_valid(rsp_valid),
		.rsp_ready(rsp_ready),
		.inputs(inputs)
	);

	initial
	begin
		clk_24 = 1'b0;
		forever #2 clk_24 = ~clk_24;
	end

	initial
	begin
		rst_n = 1'b0;
		repeat (5) @(posedge clk_24);
		rst_n <= 1'b1;
	end

	task automatic stop_run(input string reason);
		err_count++;
		$display("%s", reason);
		$display("FAIL: see errors above");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_byte(input string name, input periph_pkg::byte_t exp,
		input periph_pkg::byte_t act);
		if (act !== exp)
			stop_run($sformatf("Error %s: expected 0x%02h, actual 0x%02h", name, exp, act));
	endtask

	task automatic check_timer_range(input string name, input periph_pkg::timer_t lo,
		input periph_pkg::timer_t hi, input periph_pkg::timer_t act);
		if (act < lo || act > hi)
			stop_run($sformatf("Error %s: expected %0d to %0d, actual %0d", name, lo, hi, act));
	endtask

	// expected byte of an input page, per the read rule
	function automatic periph_pkg::byte_t ref_read(input periph_pkg::bus_req_t r,
		input periph_pkg::player_inputs_t in);
		logic [255:0] src;
		int idx;
		src = '0;
		idx = 0;
		if (r.write)
			return 8'h00;
		case (r.addr[15:8])
			`PAGE_JOYSTICK:
			begin
				src[`JOY_BITS-1:0] = in.joystick;
				idx = int'(r.addr[4:0]);
			end
			`PAGE_ANALOG_L:
			begin
				src[`ANALOG_BITS-1:0] = in.analog_l;
				idx = int'(r.addr[3:0]);
			end
			`PAGE_ANALOG_R:
			begin
				src[`ANALOG_BITS-1:0] = in.analog_r;
				idx = int'(r.addr[3:0]);
			end
			`PAGE_PADDLE:
			begin
				src[`PADDLE_BITS-1:0] = in.paddle;
				idx = int'(r.addr[2:0]);
			end
			`PAGE_SPINNER:
			begin
				src[`SPINNER_BITS-1:0] = in.spinner;
				idx = int'(r.addr[3:0]);
			end
			`PAGE_PS2_KEY:
			begin
				src[`PS2_KEY_BITS-1:0] = in.ps2_key;
				idx = int'(r.addr[0]);
			end
			`PAGE_PS2_MOUSE:
			begin
				src[`PS2_MOUSE_BITS-1:0] = in.ps2_mouse;
				idx = int'(r.addr[2:0]);
			end
			`PAGE_TIMESTAMP:
			begin
				src[`TIMESTAMP_BITS-1:0] = in.timestamp;
				idx = int'(r.addr[2:0]);
			end
			default:
				return 8'h00;
		endcase
		// bits past the input width shift in as zero
		src = src >> (8 * idx);
		return src[7:0];
	endfunction

	function automatic periph_pkg::bus_req_t make_req(input periph_pkg::byte_t page,
		input periph_pkg::byte_t low, input logic write, input periph_pkg::byte_t wdata);
		periph_pkg::bus_req_t r;
		r.addr = {page, low};
		r.wdata = wdata;
		r.write = write;
		return r;
	endfunction

	// every bit of the input bundle gets a fresh random value
	task automatic randomize_inputs();
		logic [639:0] fill;
		for (int i = 0; i < 20; i++)
			fill[i*32 +: 32] = $random(seed);
		inputs <= periph_pkg::player_inputs_t'(fill[$bits(periph_pkg::player_inputs_t)-1:0]);
	endtask

	// called just after a rising edge, returns just after the accepting edge
	task automatic send_req(input string name, input periph_pkg::bus_req_t r,
		input int kind, input periph_pkg::byte_t fixed);
		periph_pkg::byte_t exp;
		req <= r;
		req_valid <= 1'b1;
		@(negedge clk_24);
		while (!req_ready)
			@(negedge clk_24);
		// transfers on the coming edge, inputs are settled here
		exp = (kind == KIND_REF) ? ref_read(r, inputs) : fixed;
		exp_q.push_back(exp);
		kind_q.push_back(kind);
		name_q.push_back(name);
		sent_count++;
		@(posedge clk_24);
	endtask

	task automatic go_idle(input int cycles);
		req_valid <= 1'b0;
		repeat (cycles) @(posedge clk_24);
	endtask

	task automatic wait_drain(input int max_cycles);
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < max_cycles)
		begin
			@(posedge clk_24);
			n++;
		end
		if (exp_q.size() != 0)
			stop_run($sformatf("%0d responses never arrived", exp_q.size()));
	endtask

	// response side ready, randomly low while back-pressure is on
	initial
	begin
		logic [31:0] rnd;
		rsp_ready = 1'b0;
		forever
		begin
			@(posedge clk_24);
			rnd = $random(bp_seed);
			rsp_ready <= bp_on ? rnd[0] : 1'b1;
		end
	end

	// compare process, one queue entry per accepted response
	initial
	begin
		periph_pkg::byte_t exp;
		int kind;
		string name;
		forever
		begin
			@(negedge clk_24);
			if (rst_n && rsp_valid && rsp_ready)
			begin
				if (exp_q.size() == 0)
					stop_run("a response arrived with no request outstanding");
				exp = exp_q.pop_front();
				kind = kind_q.pop_front();
				name = name_q.pop_front();
				rsp_count++;
				case (kind)
					KIND_TIMER_LO: timer_lo = rsp_data;
					KIND_TIMER_HI: timer_hi = rsp_data;
					default: check_byte(name, exp, rsp_data);
				endcase
			end
		end
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_24);
		stop_run("watchdog expired before the tests finished");
	end

	initial
	begin
		periph_pkg::bus_req_t r;
		periph_pkg::byte_t page;
		logic [31:0] rnd;
		req = '0;
		req_valid = 1'b0;
		inputs = '0;
		// handshake outputs stay low while reset is held
		repeat (3) @(negedge clk_24);
		if (rsp_valid !== 1'b0 || req_ready !== 1'b0)
			stop_run("rsp_valid or req_ready was high during reset");
		@(posedge rst_n);
		@(posedge clk_24);
		@(negedge clk_24);
		if (req_ready !== 1'b1)
			stop_run("req_ready did not rise in the first cycle after reset");
		// quiet bus, any response here is an extra one
		repeat (10) @(posedge clk_24);

		// every input page and every byte index, padding too
		for (int pg = 0; pg < 8; pg++)
			for (int idx = 0; idx < 32; idx++)
			begin
				rnd = $random(seed);
				if (idx % 8 == 0)
					randomize_inputs();
				r = make_req(8'h81 + 8'(pg), {rnd[2:0], 5'(idx)}, 1'b0, 8'h00);
				send_req("input_read", r, KIND_REF, 8'h00);
				if (rnd[4])
					go_idle(int'(rnd[6:5]) + 1);
			end

		// inputs are read only, write then read back
		for (int i = 0; i < N_WRITES; i++)
		begin
			rnd = $random(seed);
			r = make_req(8'h81 + {5'b0, rnd[2:0]}, rnd[15:8], 1'b1, rnd[23:16]);
			send_req("input_write", r, KIND_REF, 8'h00);
			r.write = 1'b0;
			send_req("read_after_write", r, KIND_REF, 8'h00);
		end

		// pages outside the window, timer page left out
		for (int i = 0; i < N_UNMAPPED; i++)
		begin
			rnd = $random(seed);
			page = rnd[24] ? 8'h8a + {3'b0, rnd[4:0]} : {1'b0, rnd[6:0]};
			send_req("unmapped_read", make_req(page, rnd[15:8], 1'b0, 8'h00), KIND_REF, 8'h00);
		end

		// mixed traffic with rsp_ready toggling
		bp_on <= 1'b1;
		for (int i = 0; i < N_BP; i++)
		begin
			rnd = $random(seed);
			if (i % 16 == 0)
				randomize_inputs();
			r = make_req(8'h81 + {5'b0, rnd[2:0]}, rnd[15:8], rnd[17:16] == 2'b00, rnd[31:24]);
			send_req("backpressure", r, KIND_REF, 8'h00);
			if (rnd[20])
				go_idle(1);
		end
		bp_on <= 1'b0;
		go_idle(1);
		wait_drain(200);

		// clear, immediate read, then a read after TIMER_MS ticks
		rnd = $random(seed);
		send_req("timer_clear", make_req(`PAGE_TIMER, 8'h00, 1'b1, rnd[7:0]), KIND_FIXED, 8'h00);
		r = make_req(`PAGE_TIMER, 8'h00, 1'b0, 8'h00);
		send_req("timer_after_clear", r, KIND_FIXED, 8'h00);
		go_idle(TIMER_MS * TB_DIV);
		send_req("timer_low", r, KIND_TIMER_LO, 8'h00);
		send_req("timer_high", make_req(`PAGE_TIMER, 8'h01, 1'b0, 8'h00), KIND_TIMER_HI, 8'h00);
		go_idle(1);
		wait_drain(50);
		check_timer_range("timer_count", 16'(TIMER_MS), 16'(TIMER_MS + 1), {timer_hi, timer_lo});

		// trailing quiet period, nothing more may arrive
		repeat (20) @(posedge clk_24);
		if (rsp_count != sent_count)
			stop_run($sformatf("%0d requests sent but %0d responses received",
				sent_count, rsp_count));
		if (err_count == 0)
		begin
			$display("PASS: all tests");
			$finish;
		end
		else
			stop_run("errors were recorded during the run");
	end

endmodule

// ==== src/bus_responder.sv ====
`timescale 1ns/1ps

// request/response handshake and the two stage pipeline
// stage one is the part result registers, stage two the response register
module bus_responder (
	input logic clk_24,
	input logic rst_n,
	input logic req_valid,
	output logic req_ready,
	output logic advance,
	input periph_pkg::part_result_t reader_result,
	input periph_pkg::part_result_t timer_result,
	output periph_pkg::byte_t rsp_data,
	output logic rsp_valid,
	input logic rsp_ready
);
	// set once out of reset, opens the request side
	logic run;
	// stage one holds a request's part results
	logic s1_valid;
	logic stall;
	periph_pkg::byte_t merged;

	// response held by the master, whole pipe freezes
	assign stall = rsp_valid && !rsp_ready;

	// one request per cycle unless frozen
	assign req_ready = run && !stall;

	// parts capture on this edge
	assign advance = req_valid && req_ready;

	// at most one part hits a given page
	always_comb
	begin
		if (reader_result.hit)
			merged = reader_result.data;
		else if (timer_result.hit)
			merged = timer_result.data;
		else
			// unmapped page or write
			merged = '0;
	end

	always_ff @(posedge clk_24)
	begin
		if (!rst_n)
			run <= 1'b0;
		else
			run <= 1'b1;
	end

	// valid flags step forward on every unfrozen edge
	always_ff @(posedge clk_24)
	begin
		if (!rst_n)
		begin
			s1_valid <= 1'b0;
			rsp_valid <= 1'b0;
		end
		else if (!stall)
		begin
			s1_valid <= advance;
			rsp_valid <= s1_valid;
		end
	end

	// response byte, loaded from stage one
	always_ff @(posedge clk_24)
	begin
		if (!stall && s1_valid)
			rsp_data <= merged;
	end

endmodule

// ==== src/input_port_reader.sv ====
`timescale 1ns/1ps
`include "periph_macros.svh"

// byte readout of the player inputs, pages 0x81 to 0x88
module input_port_reader (
	input logic clk_24,
	input logic rst_n,
	input logic advance,
	input periph_pkg::bus_req_t req,
	input periph_pkg::player_inputs_t inputs,
	output periph_pkg::part_result_t result
);
	// 32 bytes covers the widest 5-bit index
	localparam int PAD_BITS = 256;

	periph_pkg::byte_t page;
	periph_pkg::byte_t sel_data;
	logic sel_hit;
	logic hit_q;
	periph_pkg::byte_t data_q;

	// zero padded copies, so out of range bytes read 0
	logic [PAD_BITS-1:0] joy_pad;
	logic [PAD_BITS-1:0] anl_pad;
	logic [PAD_BITS-1:0] anr_pad;
	logic [PAD_BITS-1:0] pad_pad;
	logic [PAD_BITS-1:0] spin_pad;
	logic [PAD_BITS-1:0] key_pad;
	logic [PAD_BITS-1:0] mouse_pad;
	logic [PAD_BITS-1:0] ts_pad;

	// byte idx of a padded vector
	function automatic periph_pkg::byte_t pick_byte(
		input logic [PAD_BITS-1:0] src,
		input logic [4:0] idx
	);
		return src[{idx, 3'b000} +: 8];
	endfunction

	assign page = req.addr[15:8];
	assign joy_pad = {{(PAD_BITS-`JOY_BITS){1'b0}}, inputs.joystick};
	assign anl_pad = {{(PAD_BITS-`ANALOG_BITS){1'b0}}, inputs.analog_l};
	assign anr_pad = {{(PAD_BITS-`ANALOG_BITS){1'b0}}, inputs.analog_r};
	assign pad_pad = {{(PAD_BITS-`PADDLE_BITS){1'b0}}, inputs.paddle};
	assign spin_pad = {{(PAD_BITS-`SPINNER_BITS){1'b0}}, inputs.spinner};
	assign key_pad = {{(PAD_BITS-`PS2_KEY_BITS){1'b0}}, inputs.ps2_key};
	assign mouse_pad = {{(PAD_BITS-`PS2_MOUSE_BITS){1'b0}}, inputs.ps2_mouse};
	assign ts_pad = {{(PAD_BITS-`TIMESTAMP_BITS){1'b0}}, inputs.timestamp};

	// page decode, index width per input
	always_comb
	begin
		sel_hit = 1'b1;
		sel_data = '0;
		case (page)
			`PAGE_JOYSTICK: sel_data = pick_byte(joy_pad, req.addr[4:0]);
			`PAGE_ANALOG_L: sel_data = pick_byte(anl_pad, {1'b0, req.addr[3:0]});
			`PAGE_ANALOG_R: sel_data = pick_byte(anr_pad, {1'b0, req.addr[3:0]});
			`PAGE_PADDLE: sel_data = pick_byte(pad_pad, {2'b00, req.addr[2:0]});
			`PAGE_SPINNER: sel_data = pick_byte(spin_pad, {1'b0, req.addr[3:0]});
			`PAGE_PS2_KEY: sel_data = pick_byte(key_pad, {4'b0000, req.addr[0]});
			`PAGE_PS2_MOUSE: sel_data = pick_byte(mouse_pad, {2'b00, req.addr[2:0]});
			`PAGE_TIMESTAMP: sel_data = pick_byte(ts_pad, {2'b00, req.addr[2:0]});
			default: sel_hit = 1'b0;
		endcase
		// inputs are read only
		if (req.write)
		begin
			sel_hit = 1'b0;
			sel_data = '0;
		end
	end

	always_ff @(posedge clk_24)
	begin
		if (!rst_n)
			hit_q <= 1'b0;
		else if (advance)
			hit_q <= sel_hit;
	end

	// captured with the request, held while stalled
	always_ff @(posedge clk_24)
	begin
		if (advance)
			data_q <= sel_data;
	end

	assign result = '{hit: hit_q, data: data_q};

endmodule

// ==== src/ms_timer.sv ====
`timescale 1ns/1ps
`include "periph_macros.svh"

// millisecond counter on page 0x89, any write clears it
module ms_timer #(
	parameter logic [31:0] div = `TIMER_DIV_DEFAULT
) (
	input logic clk_24,
	input logic rst_n,
	input logic advance,
	input periph_pkg::bus_req_t req,
	output periph_pkg::part_result_t result
);
	periph_pkg::byte_t page;
	logic sel;
	logic clear;
	logic tick;
	logic [31:0] prescale;
	periph_pkg::timer_t count;
	logic hit_q;
	periph_pkg::byte_t data_q;

	assign page = req.addr[15:8];
	assign sel = (page == `PAGE_TIMER);
	// clear only when the write is actually accepted
	assign clear = advance && sel && req.write;
	// last prescaler cycle of a millisecond
	assign tick = (prescale == div - 32'd1);

	always_ff @(posedge clk_24)
	begin
		if (!rst_n || clear)
		begin
			prescale <= '0;
			count <= '0;
		end
		else if (tick)
		begin
			prescale <= '0;
			// wraps at 16 bits
			count <= count + 16'd1;
		end
		else
			prescale <= prescale + 32'd1;
	end

	always_ff @(posedge clk_24)
	begin
		if (!rst_n)
			hit_q <= 1'b0;
		else if (advance)
			hit_q <= sel && !req.write;
	end

	// count as seen before the advance edge, low or high byte
	always_ff @(posedge clk_24)
	begin
		if (advance)
			data_q <= req.addr[0] ? count[15:8] : count[7:0];
	end

	assign result = '{hit: hit_q, data: data_q};

endmodule

// ==== src/periph_bus_top.sv ====
`timescale 1ns/1ps
`include "periph_macros.svh"

// peripheral window of the cpu bus, pages 0x81 to 0x89
module periph_bus_top #(
	parameter logic [31:0] timer_div = `TIMER_DIV_DEFAULT
) (
	input logic clk_24,
	input logic rst_n,
	input periph_pkg::bus_req_t req,
	input logic req_valid,
	output logic req_ready,
	output periph_pkg::byte_t rsp_data,
	output logic rsp_valid,
	input logic rsp_ready,
	input periph_pkg::player_inputs_t inputs
);
	logic advance;
	periph_pkg::part_result_t reader_result;
	periph_pkg::part_result_t timer_result;

	// joystick, analog, paddle, spinner, ps2 and timestamp pages
	input_port_reader u_reader (
		.clk_24(clk_24),
		.rst_n(rst_n),
		.advance(advance),
		.req(req),
		.inputs(inputs),
		.result(reader_result)
	);

	// timer page
	ms_timer #(
		.div(timer_div)
	) u_timer (
		.clk_24(clk_24),
		.rst_n(rst_n),
		.advance(advance),
		.req(req),
		.result(timer_result)
	);

	// handshake and result merge
	bus_responder u_responder (
		.clk_24(clk_24),
		.rst_n(rst_n),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.advance(advance),
		.reader_result(reader_result),
		.timer_result(timer_result),
		.rsp_data(rsp_data),
		.rsp_valid(rsp_valid),
		.rsp_ready(rsp_ready)
	);

endmodule

// ==== src/periph_macros.svh ====
`ifndef PERIPH_MACROS_SVH
`define PERIPH_MACROS_SVH

// high address byte of each memory-mapped page
`define PAGE_JOYSTICK 8'h81
`define PAGE_ANALOG_L 8'h82
`define PAGE_ANALOG_R 8'h83
`define PAGE_PADDLE 8'h84
`define PAGE_SPINNER 8'h85
`define PAGE_PS2_KEY 8'h86
`define PAGE_PS2_MOUSE 8'h87
`define PAGE_TIMESTAMP 8'h88
`define PAGE_TIMER 8'h89

// clk_24 cycles per millisecond
`define TIMER_DIV_DEFAULT 32'd24000

// input widths in bits
`define JOY_BITS 192
`define ANALOG_BITS 96
`define PADDLE_BITS 48
`define SPINNER_BITS 96
`define PS2_KEY_BITS 11
`define PS2_MOUSE_BITS 48
`define TIMESTAMP_BITS 33

`endif

// ==== src/periph_pkg.sv ====
`include "periph_macros.svh"

// shared types for the peripheral bus window
package periph_pkg;

	// cpu side address and data
	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0] byte_t;

	// millisecond count, wraps at 16 bits
	typedef logic [15:0] timer_t;

	// one bus request, write high for a store
	typedef struct packed {
		cpu_addr_t addr;
		byte_t wdata;
		logic write;
	} bus_req_t;

	// player input bundle, joystick in the top bits
	typedef struct packed {
		logic [`JOY_BITS-1:0] joystick;
		logic [`ANALOG_BITS-1:0] analog_l;
		logic [`ANALOG_BITS-1:0] analog_r;
		logic [`PADDLE_BITS-1:0] paddle;
		logic [`SPINNER_BITS-1:0] spinner;
		logic [`PS2_KEY_BITS-1:0] ps2_key;
		logic [`PS2_MOUSE_BITS-1:0] ps2_mouse;
		logic [`TIMESTAMP_BITS-1:0] timestamp;
	} player_inputs_t;

	// registered answer from one part to the responder
	typedef struct packed {
		logic hit;
		byte_t data;
	} part_result_t;

endpackage

// ==== vlog.f ====
+incdir+src
src/periph_pkg.sv
src/input_port_reader.sv
src/ms_timer.sv
src/bus_responder.sv
src/periph_bus_top.sv
sim/periph_bus_assert.sv
sim/periph_bus_tb.sv
